// File: all.f
design/tlbPkg.sv
design/tlbCam.sv
design/tlbPageStore.sv
design/tlbTranslate.sv
design/tlbCp0Regs.sv
design/tlbTop.sv
verif/tlbAssertions.sv
verif/tlbTb.sv

// File: design/tlbCam.sv
module tlbCam import tlbPkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	// Write side
	input  logic                 we,
	input  logic [tlbIndexW-1:0] waddr,
	input  logic [vpn2W-1:0]     wVpn2,
	input  logic [asidW-1:0]     wAsid,
	input  logic                 wGlobal,
	// Lookup keys
	input  logic [vpn2W-1:0]     iVpn2,
	input  logic [vpn2W-1:0]     dVpn2,
	input  logic [vpn2W-1:0]     pVpn2,
	input  logic [asidW-1:0]     curAsid,
	// Lookup results
	output logic                 iHit,
	output logic                 dHit,
	output logic                 pHit,
	output logic [tlbIndexW-1:0] iIdx,
	output logic [tlbIndexW-1:0] dIdx,
	output logic [tlbIndexW-1:0] pIdx,
	// Read-back port for TLBR
	input  logic [tlbIndexW-1:0] rdIdx,
	output logic [vpn2W-1:0]     rdVpn2,
	output logic [asidW-1:0]     rdAsid,
	output logic                 rdGlobal
);

	logic [vpn2W-1:0] tagVpn2 [tlbEntries];
	logic [asidW-1:0] tagAsid [tlbEntries];
	logic [tlbEntries-1:0] tagGlobal;

	// Per-entry match vectors
	logic [tlbEntries-1:0] asidOk;
	logic [tlbEntries-1:0] iMatch;
	logic [tlbEntries-1:0] dMatch;
	logic [tlbEntries-1:0] pMatch;

	// Lowest set bit wins
	function automatic logic [tlbIndexW-1:0] firstHit(input logic [tlbEntries-1:0] vec);
		logic [tlbIndexW-1:0] idx;
		idx = '0;
		// Scan downward so the lowest entry is the last one kept
		for (int k = tlbEntries - 1; k >= 0; k--) begin
			if (vec[k]) begin
				idx = tlbIndexW'(k);
			end
		end
		return idx;
	endfunction

	////////////////////////////////////////////////////////////
	// Tag storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int e = 0; e < tlbEntries; e++) begin
				tagVpn2[e] <= '0;
				tagAsid[e] <= '0;
			end
			tagGlobal <= '0;
		end else if (we) begin
			tagVpn2[waddr] <= wVpn2;
			tagAsid[waddr] <= wAsid;
			tagGlobal[waddr] <= wGlobal;
		end
	end

	////////////////////////////////////////////////////////////
	// Match and encode
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int e = 0; e < tlbEntries; e++) begin
			// Global entries ignore the ASID
			asidOk[e] = tagGlobal[e] || (tagAsid[e] == curAsid);
			iMatch[e] = asidOk[e] && (tagVpn2[e] == iVpn2);
			dMatch[e] = asidOk[e] && (tagVpn2[e] == dVpn2);
			pMatch[e] = asidOk[e] && (tagVpn2[e] == pVpn2);
		end
	end

	assign iHit = |iMatch;
	assign dHit = |dMatch;
	assign pHit = |pMatch;

	// Index is 0 on a miss
	assign iIdx = firstHit(iMatch);
	assign dIdx = firstHit(dMatch);
	assign pIdx = firstHit(pMatch);

	// Tag fields for TLBR
	assign rdVpn2 = tagVpn2[rdIdx];
	assign rdAsid = tagAsid[rdIdx];
	assign rdGlobal = tagGlobal[rdIdx];

endmodule

// File: design/tlbCp0Regs.sv
module tlbCp0Regs import tlbPkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  tlbOp                 op,
	// Software access
	input  logic                 regWe,
	input  cp0Reg                regSel,
	input  logic [31:0]          regWdata,
	output logic [31:0]          regRdata,
	// Probe result
	input  logic                 probeHit,
	input  logic [tlbIndexW-1:0] probeIdx,
	// Stored entry for TLBR
	input  logic [vpn2W-1:0]     rdVpn2,
	input  logic [asidW-1:0]     rdAsid,
	input  logic                 rdGlobal,
	input  logic [pfnW-1:0]      rdPfn0,
	input  logic                 rdD0,
	input  logic                 rdV0,
	input  logic [pfnW-1:0]      rdPfn1,
	input  logic                 rdD1,
	input  logic                 rdV1,
	// To the table
	output logic [31:0]          entryHi,
	output logic [31:0]          entryLo0,
	output logic [31:0]          entryLo1,
	output logic                 tlbWe,
	output logic [tlbIndexW-1:0] tlbWaddr,
	output logic [tlbIndexW-1:0] readIdx
);

	// Index
	logic idxP;
	logic [tlbIndexW-1:0] idxVal;
	// Random
	logic [tlbIndexW-1:0] randomVal;
	// EntryHi fields
	logic [vpn2W-1:0] hiVpn2;
	logic [asidW-1:0] hiAsid;
	// EntryLo fields, one set per page
	logic [pfnW-1:0] lo0Pfn;
	logic lo0D;
	logic lo0V;
	logic lo0G;
	logic [pfnW-1:0] lo1Pfn;
	logic lo1D;
	logic lo1V;
	logic lo1G;

	////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			idxP <= 1'b0;
			idxVal <= '0;
			randomVal <= '1;
			hiVpn2 <= '0;
			hiAsid <= '0;
			lo0Pfn <= '0;
			lo0D <= 1'b0;
			lo0V <= 1'b0;
			lo0G <= 1'b0;
			lo1Pfn <= '0;
			lo1D <= 1'b0;
			lo1V <= 1'b0;
			lo1G <= 1'b0;
		end else begin
			// Software writes
			if (regWe) begin
				case (regSel)
					// P is hardware-owned, only the index is writable
					regIndex: idxVal <= regWdata[tlbIndexW-1:0];
					regEntryHi: begin
						hiVpn2 <= regWdata[hiVpn2Lo +: vpn2W];
						hiAsid <= regWdata[asidW-1:0];
					end
					regEntryLo0: begin
						lo0Pfn <= regWdata[loPfnLo +: pfnW];
						lo0D <= regWdata[loDirty];
						lo0V <= regWdata[loValid];
						lo0G <= regWdata[loGlobal];
					end
					regEntryLo1: begin
						lo1Pfn <= regWdata[loPfnLo +: pfnW];
						lo1D <= regWdata[loDirty];
						lo1V <= regWdata[loValid];
						lo1G <= regWdata[loGlobal];
					end
					// Random is read-only
					default: ;
				endcase
			end

			// TLB instruction side effects
			case (op)
				opTlbr: begin
					hiVpn2 <= rdVpn2;
					hiAsid <= rdAsid;
					lo0Pfn <= rdPfn0;
					lo0D <= rdD0;
					lo0V <= rdV0;
					lo1Pfn <= rdPfn1;
					lo1D <= rdD1;
					lo1V <= rdV1;
					// Single G bit lands in both halves
					lo0G <= rdGlobal;
					lo1G <= rdGlobal;
				end
				opTlbp: begin
					idxP <= !probeHit;
					idxVal <= probeHit ? probeIdx : '0;
				end
				opTlbwr: begin
					// 4-bit wrap takes 0 back to 15
					randomVal <= randomVal - 1'b1;
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Table control
	////////////////////////////////////////////////////////////

	assign tlbWe = (op == opTlbwi) || (op == opTlbwr);
	assign tlbWaddr = (op == opTlbwr) ? randomVal : idxVal;
	assign readIdx = idxVal;

	// Registers reassembled into MIPS32 layout
	assign entryHi = {hiVpn2, {(hiVpn2Lo - asidW){1'b0}}, hiAsid};
	assign entryLo0 = {{(32 - loPfnLo - pfnW){1'b0}}, lo0Pfn, 3'b000, lo0D, lo0V, lo0G};
	assign entryLo1 = {{(32 - loPfnLo - pfnW){1'b0}}, lo1Pfn, 3'b000, lo1D, lo1V, lo1G};

	// Read mux
	always_comb begin
		regRdata = '0;
		case (regSel)
			regIndex: begin
				regRdata[idxProbe] = idxP;
				regRdata[tlbIndexW-1:0] = idxVal;
			end
			regRandom: regRdata[tlbIndexW-1:0] = randomVal;
			regEntryLo0: regRdata = entryLo0;
			regEntryLo1: regRdata = entryLo1;
			regEntryHi: regRdata = entryHi;
			default: regRdata = '0;
		endcase
	end

endmodule

// File: design/tlbPageStore.sv
module tlbPageStore import tlbPkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 we,
	input  logic [tlbIndexW-1:0] waddr,
	// Raw EntryLo values
	input  logic [31:0]          wLo0,
	input  logic [31:0]          wLo1,
	// Read addresses
	input  logic [tlbIndexW-1:0] iIdx,
	input  logic [tlbIndexW-1:0] dIdx,
	input  logic [tlbIndexW-1:0] rdIdx,
	// Instruction port entry
	output logic [pfnW-1:0]      iPfn0,
	output logic                 iD0,
	output logic                 iV0,
	output logic [pfnW-1:0]      iPfn1,
	output logic                 iD1,
	output logic                 iV1,
	// Data port entry
	output logic [pfnW-1:0]      dPfn0,
	output logic                 dD0,
	output logic                 dV0,
	output logic [pfnW-1:0]      dPfn1,
	output logic                 dD1,
	output logic                 dV1,
	// TLBR entry
	output logic [pfnW-1:0]      rdPfn0,
	output logic                 rdD0,
	output logic                 rdV0,
	output logic [pfnW-1:0]      rdPfn1,
	output logic                 rdD1,
	output logic                 rdV1
);

	// Even page
	logic [pfnW-1:0] pfn0Mem [tlbEntries];
	logic [tlbEntries-1:0] d0Mem;
	logic [tlbEntries-1:0] v0Mem;
	// Odd page
	logic [pfnW-1:0] pfn1Mem [tlbEntries];
	logic [tlbEntries-1:0] d1Mem;
	logic [tlbEntries-1:0] v1Mem;

	////////////////////////////////////////////////////////////
	// Write side, fields pulled out of the EntryLo layout
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int e = 0; e < tlbEntries; e++) begin
				pfn0Mem[e] <= '0;
				pfn1Mem[e] <= '0;
			end
			// Every entry starts invalid and clean
			d0Mem <= '0;
			v0Mem <= '0;
			d1Mem <= '0;
			v1Mem <= '0;
		end else if (we) begin
			pfn0Mem[waddr] <= wLo0[loPfnLo +: pfnW];
			d0Mem[waddr] <= wLo0[loDirty];
			v0Mem[waddr] <= wLo0[loValid];
			pfn1Mem[waddr] <= wLo1[loPfnLo +: pfnW];
			d1Mem[waddr] <= wLo1[loDirty];
			v1Mem[waddr] <= wLo1[loValid];
		end
	end

	////////////////////////////////////////////////////////////
	// Three independent read ports
	////////////////////////////////////////////////////////////

	assign iPfn0 = pfn0Mem[iIdx];
	assign iD0 = d0Mem[iIdx];
	assign iV0 = v0Mem[iIdx];
	assign iPfn1 = pfn1Mem[iIdx];
	assign iD1 = d1Mem[iIdx];
	assign iV1 = v1Mem[iIdx];

	assign dPfn0 = pfn0Mem[dIdx];
	assign dD0 = d0Mem[dIdx];
	assign dV0 = v0Mem[dIdx];
	assign dPfn1 = pfn1Mem[dIdx];
	assign dD1 = d1Mem[dIdx];
	assign dV1 = v1Mem[dIdx];

	assign rdPfn0 = pfn0Mem[rdIdx];
	assign rdD0 = d0Mem[rdIdx];
	assign rdV0 = v0Mem[rdIdx];
	assign rdPfn1 = pfn1Mem[rdIdx];
	assign rdD1 = d1Mem[rdIdx];
	assign rdV1 = v1Mem[rdIdx];

endmodule

// File: design/tlbPkg.sv
package tlbPkg;

	////////////////////////////////////////////////////////////
	// Table geometry
	////////////////////////////////////////////////////////////

	localparam int tlbEntries = 16;
	localparam int tlbIndexW = 4;

	// Field widths
	localparam int vpn2W = 19;
	localparam int asidW = 8;
	localparam int pfnW = 20;
	localparam int offsetW = 12;

	////////////////////////////////////////////////////////////
	// Register layouts, MIPS32 bit positions
	////////////////////////////////////////////////////////////

	// Index: P at bit 31, entry number in bits 3:0
	localparam int idxProbe = 31;

	// EntryHi: VPN2 in bits 31:13, ASID in bits 7:0
	localparam int hiVpn2Lo = 32 - vpn2W;

	// EntryLo: PFN in bits 25:6, D at 2, V at 1, G at 0
	localparam int loPfnLo = 6;
	localparam int loDirty = 2;
	localparam int loValid = 1;
	localparam int loGlobal = 0;

	////////////////////////////////////////////////////////////
	// Shared enums
	////////////////////////////////////////////////////////////

	// TLB instruction strobe
	typedef enum logic [2:0] {
		opNone,
		opTlbr,
		opTlbwi,
		opTlbwr,
		opTlbp
	} tlbOp;

	// Translation result
	typedef enum logic [1:0] {
		faultNone,
		faultRefill,
		faultInvalid,
		faultModified
	} tlbFault;

	// Port request kind
	typedef enum logic [1:0] {
		accNone,
		accLoad,
		accStore
	} accessKind;

	// Coprocessor-0 register select
	typedef enum logic [2:0] {
		regIndex,
		regRandom,
		regEntryLo0,
		regEntryLo1,
		regEntryHi
	} cp0Reg;

endpackage

// File: design/tlbTop.sv
module tlbTop import tlbPkg::*; (
	input  logic        clk,
	input  logic        rst,
	// Instruction port
	input  accessKind   iAccess,
	input  logic [31:0] iVaddr,
	output logic [31:0] iPaddr,
	output tlbFault     iFault,
	// Data port
	input  accessKind   dAccess,
	input  logic [31:0] dVaddr,
	output logic [31:0] dPaddr,
	output tlbFault     dFault,
	// TLB instruction strobe
	input  tlbOp        op,
	// Register port
	input  logic        regWe,
	input  cp0Reg       regSel,
	input  logic [31:0] regWdata,
	output logic [31:0] regRdata
);

	// Coprocessor register outputs
	logic [31:0] entryHi;
	logic [31:0] entryLo0;
	logic [31:0] entryLo1;
	logic tlbWe;
	logic [tlbIndexW-1:0] tlbWaddr;
	logic [tlbIndexW-1:0] readIdx;

	// CAM results
	logic iHit;
	logic dHit;
	logic pHit;
	logic [tlbIndexW-1:0] iIdx;
	logic [tlbIndexW-1:0] dIdx;
	logic [tlbIndexW-1:0] pIdx;
	logic [vpn2W-1:0] rdVpn2;
	logic [asidW-1:0] rdAsid;
	logic rdGlobal;

	// Page store read ports
	logic [pfnW-1:0] iPfn0, iPfn1, dPfn0, dPfn1, rdPfn0, rdPfn1;
	logic iD0, iV0, iD1, iV1;
	logic dD0, dV0, dD1, dV1;
	logic rdD0, rdV0, rdD1, rdV1;

	////////////////////////////////////////////////////////////
	// Registers and table
	////////////////////////////////////////////////////////////

	tlbCp0Regs cp0Regs (
		.clk(clk), .rst(rst), .op(op),
		.regWe(regWe), .regSel(regSel), .regWdata(regWdata), .regRdata(regRdata),
		.probeHit(pHit), .probeIdx(pIdx),
		.rdVpn2(rdVpn2), .rdAsid(rdAsid), .rdGlobal(rdGlobal),
		.rdPfn0(rdPfn0), .rdD0(rdD0), .rdV0(rdV0),
		.rdPfn1(rdPfn1), .rdD1(rdD1), .rdV1(rdV1),
		.entryHi(entryHi), .entryLo0(entryLo0), .entryLo1(entryLo1),
		.tlbWe(tlbWe), .tlbWaddr(tlbWaddr), .readIdx(readIdx)
	);

	// Probe key and current ASID both come from EntryHi
	// Entry is global only when both halves say so
	tlbCam cam (
		.clk(clk), .rst(rst),
		.we(tlbWe), .waddr(tlbWaddr),
		.wVpn2(entryHi[hiVpn2Lo +: vpn2W]), .wAsid(entryHi[asidW-1:0]),
		.wGlobal(entryLo0[loGlobal] & entryLo1[loGlobal]),
		.iVpn2(iVaddr[hiVpn2Lo +: vpn2W]), .dVpn2(dVaddr[hiVpn2Lo +: vpn2W]),
		.pVpn2(entryHi[hiVpn2Lo +: vpn2W]), .curAsid(entryHi[asidW-1:0]),
		.iHit(iHit), .dHit(dHit), .pHit(pHit),
		.iIdx(iIdx), .dIdx(dIdx), .pIdx(pIdx),
		.rdIdx(readIdx), .rdVpn2(rdVpn2), .rdAsid(rdAsid), .rdGlobal(rdGlobal)
	);

	tlbPageStore pageStore (
		.clk(clk), .rst(rst),
		.we(tlbWe), .waddr(tlbWaddr), .wLo0(entryLo0), .wLo1(entryLo1),
		.iIdx(iIdx), .dIdx(dIdx), .rdIdx(readIdx),
		.iPfn0(iPfn0), .iD0(iD0), .iV0(iV0), .iPfn1(iPfn1), .iD1(iD1), .iV1(iV1),
		.dPfn0(dPfn0), .dD0(dD0), .dV0(dV0), .dPfn1(dPfn1), .dD1(dD1), .dV1(dV1),
		.rdPfn0(rdPfn0), .rdD0(rdD0), .rdV0(rdV0),
		.rdPfn1(rdPfn1), .rdD1(rdD1), .rdV1(rdV1)
	);

	////////////////////////////////////////////////////////////
	// Translation ports
	////////////////////////////////////////////////////////////

	tlbTranslate iXlate (
		.access(iAccess), .vaddr(iVaddr), .hit(iHit),
		.pfn0(iPfn0), .d0(iD0), .v0(iV0), .pfn1(iPfn1), .d1(iD1), .v1(iV1),
		.paddr(iPaddr), .fault(iFault)
	);

	tlbTranslate dXlate (
		.access(dAccess), .vaddr(dVaddr), .hit(dHit),
		.pfn0(dPfn0), .d0(dD0), .v0(dV0), .pfn1(dPfn1), .d1(dD1), .v1(dV1),
		.paddr(dPaddr), .fault(dFault)
	);

endmodule

// File: design/tlbTranslate.sv
module tlbTranslate import tlbPkg::*; (
	input  accessKind       access,
	input  logic [31:0]     vaddr,
	// Lookup result for this port
	input  logic            hit,
	input  logic [pfnW-1:0] pfn0,
	input  logic            d0,
	input  logic            v0,
	input  logic [pfnW-1:0] pfn1,
	input  logic            d1,
	input  logic            v1,
	// Result
	output logic [31:0]     paddr,
	output tlbFault         fault
);

	// Even or odd page of the pair
	logic oddPage;
	logic [pfnW-1:0] selPfn;
	logic selDirty;
	logic selValid;

	// Lowest VPN bit sits right above the offset
	assign oddPage = vaddr[offsetW];

	assign selPfn = oddPage ? pfn1 : pfn0;
	assign selDirty = oddPage ? d1 : d0;
	assign selValid = oddPage ? v1 : v0;

	////////////////////////////////////////////////////////////
	// Fault priority: refill, invalid, modified
	////////////////////////////////////////////////////////////

	always_comb begin
		fault = faultNone;
		paddr = '0;
		if (access != accNone) begin
			if (!hit) begin
				fault = faultRefill;
			end else if (!selValid) begin
				fault = faultInvalid;
			end else if ((access == accStore) && !selDirty) begin
				// Store to a clean page
				fault = faultModified;
			end else begin
				paddr = {selPfn, vaddr[offsetW-1:0]};
			end
		end
	end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
	--top-module tlbTb -f all.f -o tlbSim

./obj_dir/tlbSim | tee sim.log

if grep -q "Testbench passed" sim.log; then
	echo "Simulation PASS"
	exit 0
else
	echo "Simulation FAIL"
	exit 1
fi

// File: verif/tlbAssertions.sv
module tlbAssertions import tlbPkg::*; (
	input logic                 clk,
	input logic                 rst,
	input accessKind            iAccess,
	input logic [31:0]          iVaddr,
	input logic [31:0]          iPaddr,
	input tlbFault              iFault,
	input accessKind            dAccess,
	input logic [31:0]          dVaddr,
	input logic [31:0]          dPaddr,
	input tlbFault              dFault,
	input logic [tlbIndexW-1:0] randomVal
);
	timeunit 1ns;
	timeprecision 1ps;

	// Read by the testbench at the end of the run
	int failCount = 0;

	////////////////////////////////////////////////////////////
	// Translation outputs
	////////////////////////////////////////////////////////////

	// Successful translation keeps the page offset
	iOffsetKept: assert property (@(posedge clk) disable iff (rst)
		(iAccess != accNone && iFault == faultNone) |->
			iPaddr[offsetW-1:0] == iVaddr[offsetW-1:0])
		else begin
			failCount++;
			$error("Instruction port paddr lost the page offset");
		end

	dOffsetKept: assert property (@(posedge clk) disable iff (rst)
		(dAccess != accNone && dFault == faultNone) |->
			dPaddr[offsetW-1:0] == dVaddr[offsetW-1:0])
		else begin
			failCount++;
			$error("Data port paddr lost the page offset");
		end

	// Idle port reports no fault
	iIdleNoFault: assert property (@(posedge clk) disable iff (rst)
		(iAccess == accNone) |-> iFault == faultNone)
		else begin
			failCount++;
			$error("Instruction port faulted without a request");
		end

	dIdleNoFault: assert property (@(posedge clk) disable iff (rst)
		(dAccess == accNone) |-> dFault == faultNone)
		else begin
			failCount++;
			$error("Data port faulted without a request");
		end

	// Modified fault needs a store
	iModifiedStore: assert property (@(posedge clk) disable iff (rst)
		(iFault == faultModified) |-> iAccess == accStore)
		else begin
			failCount++;
			$error("Instruction port raised a modified fault without a store");
		end

	dModifiedStore: assert property (@(posedge clk) disable iff (rst)
		(dFault == faultModified) |-> dAccess == accStore)
		else begin
			failCount++;
			$error("Data port raised a modified fault without a store");
		end

	////////////////////////////////////////////////////////////
	// Register state
	////////////////////////////////////////////////////////////

	// Random starts at the top entry
	randomAfterReset: assert property (@(posedge clk)
		$fell(rst) |-> randomVal == 4'hf)
		else begin
			failCount++;
			$error("Random was not 15 in the first cycle after reset");
		end

endmodule

bind tlbTop tlbAssertions tlbAssertions_i (
	.clk(clk),
	.rst(rst),
	.iAccess(iAccess),
	.iVaddr(iVaddr),
	.iPaddr(iPaddr),
	.iFault(iFault),
	.dAccess(dAccess),
	.dVaddr(dVaddr),
	.dPaddr(dPaddr),
	.dFault(dFault),
	.randomVal(cp0Regs.randomVal)
);

// File: verif/tlbTb.sv
module tlbTb import tlbPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	// Tests take a few hundred cycles
	localparam int cycleLimit = 2000;

	logic clk;
	logic rst;
	accessKind iAccess;
	logic [31:0] iVaddr;
	logic [31:0] iPaddr;
	tlbFault iFault;
	accessKind dAccess;
	logic [31:0] dVaddr;
	logic [31:0] dPaddr;
	tlbFault dFault;
	tlbOp op;
	logic regWe;
	cp0Reg regSel;
	logic [31:0] regWdata;
	logic [31:0] regRdata;

	integer seed = 32'h822d;
	int cycleCount = 0;
	logic [asidW-1:0] asidA;
	logic [asidW-1:0] asidB;

	// Tags shared between tests
	localparam logic [vpn2W-1:0] vpnPlain = 19'h00a0b;
	localparam logic [vpn2W-1:0] vpnGlobal = 19'h00c0d;
	localparam logic [vpn2W-1:0] vpnFault = 19'h01234;

	tlbTop tlbTop_i (
		.clk(clk), .rst(rst),
		.iAccess(iAccess), .iVaddr(iVaddr), .iPaddr(iPaddr), .iFault(iFault),
		.dAccess(dAccess), .dVaddr(dVaddr), .dPaddr(dPaddr), .dFault(dFault),
		.op(op),
		.regWe(regWe), .regSel(regSel), .regWdata(regWdata), .regRdata(regRdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			failRun("Timeout, the tests did not finish within the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////
	// Reporting and compare
	////////////////////////////////////////////////////////////

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic checkFault(input string name, input tlbFault expected, input tlbFault actual);
		if (actual !== expected) begin
			failRun($sformatf("mismatch %s expected %s actual %s",
				name, expected.name(), actual.name()));
		end
	endtask

	task automatic checkAddr(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			failRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic checkReg(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			failRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Register images in MIPS32 layout
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] makeHi(input logic [vpn2W-1:0] vpn2,
			input logic [asidW-1:0] asid);
		return {vpn2, 5'b00000, asid};
	endfunction

	function automatic logic [31:0] makeLo(input logic [pfnW-1:0] pfn, input logic d,
			input logic v, input logic g);
		return {6'b000000, pfn, 3'b000, d, v, g};
	endfunction

	// Bit 12 picks the odd page
	function automatic logic [31:0] makeVaddr(input logic [vpn2W-1:0] vpn2, input logic odd,
			input logic [offsetW-1:0] off);
		return {vpn2, odd, off};
	endfunction

	////////////////////////////////////////////////////////////
	// Bus helpers, all entered 2 ns after a rising edge
	////////////////////////////////////////////////////////////

	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic writeReg(input cp0Reg sel, input logic [31:0] data);
		regWe = 1'b1;
		regSel = sel;
		regWdata = data;
		nextCycle();
		regWe = 1'b0;
	endtask

	task automatic strobeOp(input tlbOp o);
		op = o;
		nextCycle();
		op = opNone;
	endtask

	task automatic readReg(input cp0Reg sel, output logic [31:0] data);
		regSel = sel;
		@(negedge clk);
		data = regRdata;
		nextCycle();
	endtask

	task automatic expectReg(input string name, input cp0Reg sel, input logic [31:0] expected);
		logic [31:0] got;
		readReg(sel, got);
		checkReg(name, expected, got);
	endtask

	task automatic writeEntry(input logic [tlbIndexW-1:0] idx, input logic [31:0] hi,
			input logic [31:0] lo0, input logic [31:0] lo1);
		writeReg(regIndex, 32'(idx));
		writeReg(regEntryHi, hi);
		writeReg(regEntryLo0, lo0);
		writeReg(regEntryLo1, lo1);
		strobeOp(opTlbwi);
	endtask

	// One port at a time, the other one idle
	task automatic lookup(input string name, input logic dataPort, input accessKind acc,
			input logic [31:0] va, input tlbFault expFault, input logic [31:0] expAddr);
		tlbFault gotFault;
		logic [31:0] gotAddr;
		if (dataPort) begin
			dAccess = acc;
			dVaddr = va;
		end else begin
			iAccess = acc;
			iVaddr = va;
		end
		@(negedge clk);
		if (dataPort) begin
			gotFault = dFault;
			gotAddr = dPaddr;
		end else begin
			gotFault = iFault;
			gotAddr = iPaddr;
		end
		nextCycle();
		iAccess = accNone;
		dAccess = accNone;
		checkFault(name, expFault, gotFault);
		checkAddr(name, expAddr, gotAddr);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic testReset();
		// Nonzero VPN2 so the zeroed entries never match
		lookup("reset ifetch", 1'b0, accLoad, 32'h0040_1234, faultRefill, 32'h0);
		lookup("reset dload", 1'b1, accLoad, 32'h0040_1234, faultRefill, 32'h0);
		lookup("reset idle", 1'b1, accNone, 32'h0040_1234, faultNone, 32'h0);
		expectReg("reset random", regRandom, 32'd15);
		expectReg("reset index", regIndex, 32'h0);
		expectReg("reset entryhi", regEntryHi, 32'h0);
	endtask

	task automatic testWriteRead();
		logic [31:0] hi;
		hi = makeHi(19'h12345, asidA);
		writeEntry(4'd3, hi, makeLo(20'habcde, 1'b1, 1'b1, 1'b1),
			makeLo(20'h13579, 1'b0, 1'b1, 1'b0));
		writeReg(regEntryHi, 32'h0);
		writeReg(regEntryLo0, 32'h0);
		writeReg(regEntryLo1, 32'h0);
		strobeOp(opTlbr);
		// Stored G is the AND of both halves
		expectReg("tlbr entryhi", regEntryHi, hi);
		expectReg("tlbr entrylo0", regEntryLo0, makeLo(20'habcde, 1'b1, 1'b1, 1'b0));
		expectReg("tlbr entrylo1", regEntryLo1, makeLo(20'h13579, 1'b0, 1'b1, 1'b0));
		expectReg("tlbr index kept", regIndex, 32'd3);
	endtask

	task automatic testTranslate();
		logic [offsetW-1:0] off0;
		logic [offsetW-1:0] off1;
		tlbFault gotIFault;
		tlbFault gotDFault;
		logic [31:0] gotIAddr;
		logic [31:0] gotDAddr;
		off0 = offsetW'($random(seed));
		off1 = offsetW'($random(seed));
		// Entry 5 private to asidA, entry 6 global
		writeEntry(4'd5, makeHi(vpnPlain, asidA), makeLo(20'h11111, 1'b1, 1'b1, 1'b0),
			makeLo(20'h22222, 1'b1, 1'b1, 1'b0));
		writeEntry(4'd6, makeHi(vpnGlobal, asidA), makeLo(20'h33333, 1'b1, 1'b1, 1'b1),
			makeLo(20'h44444, 1'b1, 1'b1, 1'b1));
		lookup("xlate even", 1'b1, accLoad, makeVaddr(vpnPlain, 1'b0, off0),
			faultNone, {20'h11111, off0});
		lookup("xlate odd", 1'b0, accLoad, makeVaddr(vpnPlain, 1'b1, off1),
			faultNone, {20'h22222, off1});

		// Switch to another address space
		writeReg(regEntryHi, makeHi(vpnPlain, asidB));
		lookup("xlate other asid", 1'b1, accLoad, makeVaddr(vpnPlain, 1'b0, off0),
			faultRefill, 32'h0);
		lookup("xlate global", 1'b1, accLoad, makeVaddr(vpnGlobal, 1'b0, off0),
			faultNone, {20'h33333, off0});

		// Both ports in one cycle
		writeReg(regEntryHi, makeHi(vpnPlain, asidA));
		iAccess = accLoad;
		iVaddr = makeVaddr(vpnPlain, 1'b0, off0);
		dAccess = accStore;
		dVaddr = makeVaddr(vpnGlobal, 1'b1, off1);
		@(negedge clk);
		gotIFault = iFault;
		gotIAddr = iPaddr;
		gotDFault = dFault;
		gotDAddr = dPaddr;
		nextCycle();
		iAccess = accNone;
		dAccess = accNone;
		checkFault("dual ifetch", faultNone, gotIFault);
		checkAddr("dual ifetch", {20'h11111, off0}, gotIAddr);
		checkFault("dual dstore", faultNone, gotDFault);
		checkAddr("dual dstore", {20'h44444, off1}, gotDAddr);
	endtask

	task automatic testFaults();
		logic [offsetW-1:0] off;
		off = offsetW'($random(seed));
		// Even page invalid, odd page valid but clean
		writeEntry(4'd7, makeHi(vpnFault, asidA), makeLo(20'h55555, 1'b0, 1'b0, 1'b0),
			makeLo(20'h66666, 1'b0, 1'b1, 1'b0));
		lookup("fault invalid load", 1'b1, accLoad, makeVaddr(vpnFault, 1'b0, off),
			faultInvalid, 32'h0);
		lookup("fault invalid fetch", 1'b0, accLoad, makeVaddr(vpnFault, 1'b0, off),
			faultInvalid, 32'h0);
		// Invalid outranks modified
		lookup("fault invalid store", 1'b1, accStore, makeVaddr(vpnFault, 1'b0, off),
			faultInvalid, 32'h0);
		lookup("fault modified", 1'b1, accStore, makeVaddr(vpnFault, 1'b1, off),
			faultModified, 32'h0);
		lookup("fault clean load", 1'b1, accLoad, makeVaddr(vpnFault, 1'b1, off),
			faultNone, {20'h66666, off});
		lookup("fault clean fetch", 1'b0, accLoad, makeVaddr(vpnFault, 1'b1, off),
			faultNone, {20'h66666, off});
	endtask

	task automatic testProbe();
		writeReg(regEntryHi, makeHi(vpnPlain, asidA));
		strobeOp(opTlbp);
		expectReg("probe hit", regIndex, 32'd5);
		writeReg(regEntryHi, makeHi(vpnGlobal, asidB));
		strobeOp(opTlbp);
		expectReg("probe global", regIndex, 32'd6);
		writeReg(regEntryHi, makeHi(19'h7ffff, asidA));
		strobeOp(opTlbp);
		expectReg("probe miss", regIndex, 32'h8000_0000);
	endtask

	task automatic testWriteRandom();
		int randomExp;
		int written [3];
		randomExp = 15;
		for (int k = 0; k < 3; k++) begin
			writeReg(regEntryHi, makeHi(19'h02000 + vpn2W'(k), asidA));
			writeReg(regEntryLo0, makeLo(20'h70000 + pfnW'(k), 1'b1, 1'b1, 1'b0));
			writeReg(regEntryLo1, makeLo(20'h78000 + pfnW'(k), 1'b1, 1'b1, 1'b0));
			strobeOp(opTlbwr);
			written[k] = randomExp;
			randomExp = (randomExp == 0) ? 15 : randomExp - 1;
		end
		// Read each slot back through TLBR
		for (int k = 0; k < 3; k++) begin
			writeReg(regIndex, 32'(written[k]));
			strobeOp(opTlbr);
			expectReg("tlbwr entryhi", regEntryHi, makeHi(19'h02000 + vpn2W'(k), asidA));
			expectReg("tlbwr entrylo0", regEntryLo0,
				makeLo(20'h70000 + pfnW'(k), 1'b1, 1'b1, 1'b0));
			expectReg("tlbwr entrylo1", regEntryLo1,
				makeLo(20'h78000 + pfnW'(k), 1'b1, 1'b1, 1'b0));
		end
		expectReg("tlbwr random", regRandom, 32'(randomExp));
	endtask

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst = 1'b1;
		iAccess = accNone;
		iVaddr = 32'h0;
		dAccess = accNone;
		dVaddr = 32'h0;
		op = opNone;
		regWe = 1'b0;
		regSel = regIndex;
		regWdata = 32'h0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		asidA = asidW'($random(seed));
		// Always differs from asidA
		asidB = asidA ^ 8'h5a;

		testReset();
		testWriteRead();
		testTranslate();
		testFaults();
		testProbe();
		testWriteRandom();

		if (tlbTop_i.tlbAssertions_i.failCount == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			failRun("One or more bound assertions failed during the run");
		end
	end

endmodule
